// ==== verilog/arbiter_pkg.sv ====
// Arbitrator package: port and memory sizes, transfer threshold, scan and burst state types
`default_nettype none

package arbiter_pkg;

    // Four write FIFOs and four read FIFOs
    localparam int NUM_PORTS = 4;
    localparam int PORT_BITS = 2;

    // FIFO side moves bytes, memory side moves 16-bit words
    localparam int BYTE_BITS = 8;
    localparam int WORD_BITS = 16;

    // Word address into the shared memory
    localparam int ADDR_BITS = 12;

    // Each port owns one region, base is port index << REGION_WORD_BITS
    localparam int REGION_WORD_BITS = 10;

    // FIFO fill level and burst byte count
    localparam int LEVEL_BITS = 11;

    // Running stored / delivered byte counts per port
    localparam int COUNT_BITS = 32;

    // A burst starts only when more than this many bytes are waiting
    localparam int MIN_CHUNK = 4;

    // Outer state of the scanner
    typedef enum logic [1:0] {
        SCAN_WRITE,
        SCAN_READ,
        XFER_WRITE,
        XFER_READ
    } scan_state_e;

    // Phase inside one burst
    typedef enum logic [1:0] {
        PHASE_START,
        PHASE_WAIT,
        PHASE_ACTIVE,
        PHASE_DONE
    } burst_phase_e;

endpackage

`default_nettype wire

// ==== verilog/port_scanner.sv ====
// Port scanner: scan and burst FSM, per-port byte accounting, memory address generation
`default_nettype none

module port_scanner (
    input  logic clk,
    input  logic reset,
    input  logic [arbiter_pkg::NUM_PORTS-1:0][arbiter_pkg::LEVEL_BITS-1:0] write_level,
    input  logic                                                           mem_wait,
    input  logic                                                           word_written,
    output logic [arbiter_pkg::NUM_PORTS-1:0]                              write_read,
    output logic                                                           mem_oe,
    output logic [arbiter_pkg::ADDR_BITS-1:0]                              mem_addr,
    output logic [arbiter_pkg::PORT_BITS-1:0]                              xfer_port
);

    arbiter_pkg::scan_state_e  state;
    arbiter_pkg::burst_phase_e phase;
    logic [arbiter_pkg::PORT_BITS-1:0] port;

    // Per-port accounting, stored minus delivered is what a read port is owed
    logic [arbiter_pkg::COUNT_BITS-1:0]       stored_bytes    [arbiter_pkg::NUM_PORTS];
    logic [arbiter_pkg::COUNT_BITS-1:0]       delivered_bytes [arbiter_pkg::NUM_PORTS];
    logic [arbiter_pkg::REGION_WORD_BITS-1:0] write_ptr       [arbiter_pkg::NUM_PORTS];
    logic [arbiter_pkg::REGION_WORD_BITS-1:0] read_ptr        [arbiter_pkg::NUM_PORTS];

    // Burst counters
    logic [arbiter_pkg::LEVEL_BITS-1:0] pops_left;
    logic [arbiter_pkg::LEVEL_BITS-1:0] words_left;
    // Cycles left for the splitter to push the last word
    logic [1:0]                         tail;

    logic [arbiter_pkg::LEVEL_BITS-1:0] even_level;
    logic [arbiter_pkg::COUNT_BITS-1:0] pending;
    logic                               last_port;

    // Only whole words go to memory, odd byte stays in the FIFO
    assign even_level = {write_level[port][arbiter_pkg::LEVEL_BITS-1:1], 1'b0};
    assign pending    = stored_bytes[port] - delivered_bytes[port];
    assign last_port  = (port == arbiter_pkg::PORT_BITS'(arbiter_pkg::NUM_PORTS - 1));
    assign xfer_port  = port;

    // Region base is the port index on the top address bits
    assign mem_addr = (state == arbiter_pkg::XFER_WRITE) ? {port, write_ptr[port]}
                                                         : {port, read_ptr[port]};

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= arbiter_pkg::SCAN_WRITE;
            phase      <= arbiter_pkg::PHASE_START;
            port       <= '0;
            write_read <= '0;
            mem_oe     <= 1'b0;
            pops_left  <= '0;
            words_left <= '0;
            tail       <= '0;
            for (int i = 0; i < arbiter_pkg::NUM_PORTS; i++) begin
                stored_bytes[i]    <= '0;
                delivered_bytes[i] <= '0;
                write_ptr[i]       <= '0;
                read_ptr[i]        <= '0;
            end
        end else begin
            // Word landed in memory
            if (word_written) begin
                write_ptr[port] <= write_ptr[port] + 1'b1;
                words_left      <= words_left - 1'b1;
            end
            // Each read request returns two bytes to the port
            if (mem_oe) begin
                read_ptr[port]        <= read_ptr[port] + 1'b1;
                delivered_bytes[port] <= delivered_bytes[port] + arbiter_pkg::COUNT_BITS'(2);
            end

            case (state)
                arbiter_pkg::SCAN_WRITE: begin
                    if (even_level > arbiter_pkg::MIN_CHUNK) begin
                        // Latch the byte count on entry
                        stored_bytes[port] <= stored_bytes[port]
                                              + arbiter_pkg::COUNT_BITS'(even_level);
                        pops_left  <= even_level;
                        words_left <= {1'b0, even_level[arbiter_pkg::LEVEL_BITS-1:1]};
                        phase      <= arbiter_pkg::PHASE_START;
                        state      <= arbiter_pkg::XFER_WRITE;
                    end else begin
                        port <= port + 1'b1;
                        if (last_port)
                            state <= arbiter_pkg::SCAN_READ;
                    end
                end
                arbiter_pkg::SCAN_READ: begin
                    if (pending > arbiter_pkg::MIN_CHUNK) begin
                        words_left <= pending[arbiter_pkg::LEVEL_BITS:1];
                        phase      <= arbiter_pkg::PHASE_START;
                        state      <= arbiter_pkg::XFER_READ;
                    end else begin
                        port <= port + 1'b1;
                        if (last_port)
                            state <= arbiter_pkg::SCAN_WRITE;
                    end
                end
                default: begin
                    case (phase)
                        arbiter_pkg::PHASE_START: begin
                            phase <= arbiter_pkg::PHASE_WAIT;
                        end
                        arbiter_pkg::PHASE_WAIT: begin
                            // Memory busy, hold until mem_wait drops
                            if (!mem_wait) begin
                                phase <= arbiter_pkg::PHASE_ACTIVE;
                                if (state == arbiter_pkg::XFER_WRITE) begin
                                    write_read <= arbiter_pkg::NUM_PORTS'(1) << port;
                                    pops_left  <= pops_left - 1'b1;
                                end else begin
                                    mem_oe     <= 1'b1;
                                    words_left <= words_left - 1'b1;
                                    tail       <= 2'd2;
                                end
                            end
                        end
                        arbiter_pkg::PHASE_ACTIVE: begin
                            if (state == arbiter_pkg::XFER_WRITE) begin
                                // One pop per clock, then wait for the last word
                                if (pops_left != '0)
                                    pops_left <= pops_left - 1'b1;
                                else
                                    write_read <= '0;
                                if (write_read == '0 && words_left == '0)
                                    phase <= arbiter_pkg::PHASE_DONE;
                            end else begin
                                // Read request every second cycle
                                if (mem_oe) begin
                                    mem_oe <= 1'b0;
                                end else if (words_left != '0) begin
                                    mem_oe     <= 1'b1;
                                    words_left <= words_left - 1'b1;
                                end else if (tail != '0) begin
                                    tail <= tail - 1'b1;
                                end else begin
                                    phase <= arbiter_pkg::PHASE_DONE;
                                end
                            end
                        end
                        default: begin
                            // Resume scanning at the next port
                            port  <= port + 1'b1;
                            phase <= arbiter_pkg::PHASE_START;
                            if ((state == arbiter_pkg::XFER_WRITE) != last_port)
                                state <= arbiter_pkg::SCAN_WRITE;
                            else
                                state <= arbiter_pkg::SCAN_READ;
                        end
                    endcase
                end
            endcase
        end
    end

    // At most one write FIFO popped at a time
    assert property (@(posedge clk) disable iff (reset) $onehot0(write_read))
        else $error("write_read not one-hot");

    // Read requests only inside a read burst
    assert property (@(posedge clk) disable iff (reset)
        mem_oe |-> state == arbiter_pkg::XFER_READ)
        else $error("mem_oe outside read transfer");

endmodule

`default_nettype wire

// ==== verilog/word_assembler.sv ====
// Word assembler: packs popped write bytes into 16-bit words and issues memory writes
`default_nettype none

module word_assembler (
    input  logic clk,
    input  logic reset,
    input  logic [arbiter_pkg::NUM_PORTS-1:0][arbiter_pkg::BYTE_BITS-1:0] write_data,
    input  logic [arbiter_pkg::NUM_PORTS-1:0]                             write_read,
    input  logic [arbiter_pkg::PORT_BITS-1:0]                             xfer_port,
    output logic [arbiter_pkg::WORD_BITS-1:0]                             mem_wdata,
    output logic                                                          mem_we,
    output logic                                                          word_written
);

    // FIFO byte shows up the cycle after its pop
    logic                              pop_d;
    // Next byte goes to the high half
    logic                              high_half;
    logic [arbiter_pkg::BYTE_BITS-1:0] pop_byte;
    logic [arbiter_pkg::BYTE_BITS-1:0] low_byte;
    logic [arbiter_pkg::BYTE_BITS-1:0] high_byte;

    assign pop_byte = write_data[xfer_port];

    always_ff @(posedge clk) begin
        if (reset) begin
            pop_d     <= 1'b0;
            high_half <= 1'b0;
            mem_we    <= 1'b0;
        end else begin
            pop_d  <= |write_read;
            // Write once the high half is in
            mem_we <= pop_d & high_half;
            if (pop_d)
                high_half <= ~high_half;
        end
    end

    // Byte lanes, lower byte first
    always_ff @(posedge clk) begin
        if (pop_d) begin
            if (high_half)
                high_byte <= pop_byte;
            else
                low_byte <= pop_byte;
        end
    end

    assign mem_wdata    = {high_byte, low_byte};
    assign word_written = mem_we;

    // Two bytes per word, so never back-to-back writes
    assert property (@(posedge clk) disable iff (reset) mem_we |=> !mem_we)
        else $error("mem_we in consecutive cycles");

endmodule

`default_nettype wire

// ==== verilog/word_splitter.sv ====
// Word splitter: splits memory read words into low and high byte pushes to the read port
`default_nettype none

module word_splitter (
    input  logic clk,
    input  logic reset,
    input  logic [arbiter_pkg::WORD_BITS-1:0] mem_rdata,
    input  logic                              mem_oe,
    input  logic [arbiter_pkg::PORT_BITS-1:0] xfer_port,
    output logic [arbiter_pkg::NUM_PORTS-1:0] read_write,
    output logic [arbiter_pkg::BYTE_BITS-1:0] read_data
);

    // Request pipeline stages for data valid, low push and high push
    logic oe_d;
    logic lo_valid;
    logic hi_valid;
    // Port travels alongside the request
    logic [arbiter_pkg::PORT_BITS-1:0] port_d;
    logic [arbiter_pkg::PORT_BITS-1:0] lo_port;
    logic [arbiter_pkg::PORT_BITS-1:0] hi_port;
    logic [arbiter_pkg::WORD_BITS-1:0] word_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            oe_d     <= 1'b0;
            lo_valid <= 1'b0;
            hi_valid <= 1'b0;
        end else begin
            oe_d     <= mem_oe;
            lo_valid <= oe_d;
            hi_valid <= lo_valid;
        end
    end

    always_ff @(posedge clk) begin
        port_d  <= xfer_port;
        lo_port <= port_d;
        hi_port <= lo_port;
        // mem_rdata valid one cycle after the request
        if (oe_d)
            word_q <= mem_rdata;
    end

    // Low byte first, high byte the cycle after
    always_comb begin
        read_write = '0;
        read_data  = word_q[arbiter_pkg::BYTE_BITS-1:0];
        if (lo_valid) begin
            read_write = arbiter_pkg::NUM_PORTS'(1) << lo_port;
        end else if (hi_valid) begin
            read_write = arbiter_pkg::NUM_PORTS'(1) << hi_port;
            read_data  = word_q[arbiter_pkg::WORD_BITS-1:arbiter_pkg::BYTE_BITS];
        end
    end

    assert property (@(posedge clk) disable iff (reset) $onehot0(read_write))
        else $error("read_write not one-hot");

endmodule

`default_nettype wire

// ==== verilog/memory_arbitrator.sv ====
// Byte to word memory arbitrator top level: scanner, word assembler and word splitter
`default_nettype none

module memory_arbitrator (
    input  logic clk,
    input  logic reset,
    // Write FIFOs, one lane per port
    input  logic [arbiter_pkg::NUM_PORTS-1:0][arbiter_pkg::LEVEL_BITS-1:0] write_level,
    input  logic [arbiter_pkg::NUM_PORTS-1:0][arbiter_pkg::BYTE_BITS-1:0]  write_data,
    output logic [arbiter_pkg::NUM_PORTS-1:0]                              write_read,
    // Read FIFOs share one data bus, push strobe selects the port
    output logic [arbiter_pkg::NUM_PORTS-1:0]                              read_write,
    output logic [arbiter_pkg::BYTE_BITS-1:0]                              read_data,
    // Shared 16-bit memory
    output logic [arbiter_pkg::ADDR_BITS-1:0]                              mem_addr,
    output logic [arbiter_pkg::WORD_BITS-1:0]                              mem_wdata,
    input  logic [arbiter_pkg::WORD_BITS-1:0]                              mem_rdata,
    output logic                                                           mem_we,
    output logic                                                           mem_oe,
    input  logic                                                           mem_wait
);

    // Port under transfer, shared by all three blocks
    logic [arbiter_pkg::PORT_BITS-1:0] xfer_port;
    // Pulse with each memory write, moves the write pointer
    logic                              word_written;

    // Scan order, burst phases, byte accounting and addresses
    port_scanner i_port_scanner (
        .clk          (clk),
        .reset        (reset),
        .write_level  (write_level),
        .mem_wait     (mem_wait),
        .word_written (word_written),
        .write_read   (write_read),
        .mem_oe       (mem_oe),
        .mem_addr     (mem_addr),
        .xfer_port    (xfer_port)
    );

    // Popped bytes packed two per word, low byte first
    word_assembler i_word_assembler (
        .clk          (clk),
        .reset        (reset),
        .write_data   (write_data),
        .write_read   (write_read),
        .xfer_port    (xfer_port),
        .mem_wdata    (mem_wdata),
        .mem_we       (mem_we),
        .word_written (word_written)
    );

    // Read words split back into low then high byte
    word_splitter i_word_splitter (
        .clk        (clk),
        .reset      (reset),
        .mem_rdata  (mem_rdata),
        .mem_oe     (mem_oe),
        .xfer_port  (xfer_port),
        .read_write (read_write),
        .read_data  (read_data)
    );

endmodule

`default_nettype wire

// ==== tb/tb_port_models.sv ====
// Testbench models: write FIFOs, read byte collectors, wait-stated word memory
`default_nettype none

module tb_port_models (
    input  logic clk,
    // Load request from the testbench top
    input  logic                                  load_valid,
    input  logic [arbiter_pkg::NUM_PORTS-1:0]     load_mask,
    input  logic [7:0]                            load_count,
    input  logic [7:0]                            wait_cycles,
    // Scanner has just entered a burst
    input  logic                                  burst_start,
    // DUT write side
    output logic [arbiter_pkg::NUM_PORTS-1:0][arbiter_pkg::LEVEL_BITS-1:0] write_level,
    output logic [arbiter_pkg::NUM_PORTS-1:0][arbiter_pkg::BYTE_BITS-1:0]  write_data,
    input  logic [arbiter_pkg::NUM_PORTS-1:0]     write_read,
    // DUT read side
    input  logic [arbiter_pkg::NUM_PORTS-1:0]     read_write,
    input  logic [arbiter_pkg::BYTE_BITS-1:0]     read_data,
    // DUT memory side
    input  logic [arbiter_pkg::ADDR_BITS-1:0]     mem_addr,
    input  logic [arbiter_pkg::WORD_BITS-1:0]     mem_wdata,
    output logic [arbiter_pkg::WORD_BITS-1:0]     mem_rdata,
    input  logic                                  mem_we,
    input  logic                                  mem_oe,
    output logic                                  mem_wait
);

    logic [arbiter_pkg::BYTE_BITS-1:0] fifo     [arbiter_pkg::NUM_PORTS][$];
    // Every byte ever loaded, in load order
    logic [arbiter_pkg::BYTE_BITS-1:0] load_log [arbiter_pkg::NUM_PORTS][$];
    // Every byte pushed to a read port
    logic [arbiter_pkg::BYTE_BITS-1:0] read_q   [arbiter_pkg::NUM_PORTS][$];
    logic [arbiter_pkg::WORD_BITS-1:0] mem      [1 << arbiter_pkg::ADDR_BITS];
    int                                region_writes [arbiter_pkg::NUM_PORTS];
    // Cycles with any strobe from the DUT
    int                                activity;
    // Cycles with a DUT strobe while mem_wait was high
    int                                wait_violations;
    logic [31:0]                       rand_state;
    logic [7:0]                        wait_cnt;
    logic                              busy;

    // Xorshift32 step
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        rand_state      = 32'd96;
        write_level     = '0;
        write_data      = '0;
        mem_rdata       = '0;
        wait_cnt        = '0;
        activity        = 0;
        wait_violations = 0;
        for (int i = 0; i < arbiter_pkg::NUM_PORTS; i++)
            region_writes[i] = 0;
        // Fill pattern from the whole address
        for (int a = 0; a < (1 << arbiter_pkg::ADDR_BITS); a++)
            mem[a] = {a[3:0], a[11:0]} ^ 16'h3c3c;
    end

    // FIFO pops, loads and level update
    always @(posedge clk) begin
        for (int k = 0; k < arbiter_pkg::NUM_PORTS; k++) begin
            if (write_read[k] && fifo[k].size() > 0)
                write_data[k] <= fifo[k].pop_front();
            if (load_valid && load_mask[k]) begin
                for (int n = 0; n < int'(load_count); n++) begin
                    rand_state = xorshift(rand_state);
                    fifo[k].push_back(rand_state[7:0]);
                    load_log[k].push_back(rand_state[7:0]);
                end
            end
            write_level[k] <= arbiter_pkg::LEVEL_BITS'(fifo[k].size());
        end
    end

    // Read side always accepts
    always @(posedge clk) begin
        for (int k = 0; k < arbiter_pkg::NUM_PORTS; k++)
            if (read_write[k])
                read_q[k].push_back(read_data);
    end

    // Word memory, one cycle read
    always @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
            region_writes[mem_addr[arbiter_pkg::ADDR_BITS-1:arbiter_pkg::REGION_WORD_BITS]]++;
        end
        if (mem_oe)
            mem_rdata <= mem[mem_addr];
    end

    assign busy = (|write_read) | (|read_write) | mem_we | mem_oe;

    // Memory stays busy for wait_cycles after each burst start
    always @(posedge clk) begin
        if (busy)
            activity++;
        // Any access here means the burst did not hold for mem_wait
        if (busy && mem_wait)
            wait_violations++;
        if (burst_start)
            wait_cnt <= wait_cycles;
        else if (wait_cnt != 8'd0)
            wait_cnt <= wait_cnt - 8'd1;
    end

    assign mem_wait = (wait_cnt != 8'd0);

endmodule

`default_nettype wire

// ==== tb/tb_memory_arbitrator.sv ====
// Testbench top: clock, reset, stimulus table, checks, watchdog and reporting
`default_nettype none

module tb_memory_arbitrator;

    localparam int ROWS    = 6;
    localparam int PERIOD  = 40;
    localparam int SETTLE  = 30;
    localparam int IDLE    = 40;
    // Port 4 in the table means all four ports at once
    localparam int ALL     = 4;

    // One column each for port, bytes loaded, mem_wait cycles, stored and returned bytes
    int row_port   [ROWS] = '{0, 1, 2, 3, 1, ALL};
    int row_load   [ROWS] = '{8, 4, 9, 8, 6, 8};
    int row_wait   [ROWS] = '{0, 0, 0, 6, 3, 2};
    int row_stored [ROWS] = '{8, 0, 8, 8, 10, 8};
    int row_ret    [ROWS] = '{8, 0, 8, 8, 10, 8};

    logic clk;
    logic reset;
    logic                                  load_valid;
    logic [arbiter_pkg::NUM_PORTS-1:0]     load_mask;
    logic [7:0]                            load_count;
    logic [7:0]                            wait_cycles;
    logic                                  burst_start;

    logic [arbiter_pkg::NUM_PORTS-1:0][arbiter_pkg::LEVEL_BITS-1:0] write_level;
    logic [arbiter_pkg::NUM_PORTS-1:0][arbiter_pkg::BYTE_BITS-1:0]  write_data;
    logic [arbiter_pkg::NUM_PORTS-1:0] write_read;
    logic [arbiter_pkg::NUM_PORTS-1:0] read_write;
    logic [arbiter_pkg::BYTE_BITS-1:0] read_data;
    logic [arbiter_pkg::ADDR_BITS-1:0] mem_addr;
    logic [arbiter_pkg::WORD_BITS-1:0] mem_wdata;
    logic [arbiter_pkg::WORD_BITS-1:0] mem_rdata;
    logic                              mem_we;
    logic                              mem_oe;
    logic                              mem_wait;

    int errors;
    int passed;
    int failed;
    // Bytes already checked and word offsets used, per port
    int consumed [arbiter_pkg::NUM_PORTS];
    int word_off [arbiter_pkg::NUM_PORTS];

    memory_arbitrator i_memory_arbitrator (
        .clk         (clk),
        .reset       (reset),
        .write_level (write_level),
        .write_data  (write_data),
        .write_read  (write_read),
        .read_write  (read_write),
        .read_data   (read_data),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_we      (mem_we),
        .mem_oe      (mem_oe),
        .mem_wait    (mem_wait)
    );

    // Scanner in the first cycle of a burst starts the memory wait states
    assign burst_start =
        (i_memory_arbitrator.i_port_scanner.state == arbiter_pkg::XFER_WRITE
         || i_memory_arbitrator.i_port_scanner.state == arbiter_pkg::XFER_READ)
        && i_memory_arbitrator.i_port_scanner.phase == arbiter_pkg::PHASE_START;

    tb_port_models i_models (
        .clk         (clk),
        .load_valid  (load_valid),
        .load_mask   (load_mask),
        .load_count  (load_count),
        .wait_cycles (wait_cycles),
        .burst_start (burst_start),
        .write_level (write_level),
        .write_data  (write_data),
        .write_read  (write_read),
        .read_write  (read_write),
        .read_data   (read_data),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_we      (mem_we),
        .mem_oe      (mem_oe),
        .mem_wait    (mem_wait)
    );

    always #(PERIOD / 2) clk = ~clk;

    // Cycle budget of one row, scaled by bytes, ports and wait states
    function automatic int row_budget(input int r);
        int nports;
        nports = (row_port[r] == ALL) ? 4 : 1;
        return 200 + 16 * row_load[r] * nports + 4 * row_wait[r] * nports;
    endfunction

    // Global watchdog
    initial begin
        int total;
        total = 8 + IDLE + 100;
        for (int r = 0; r < ROWS; r++)
            total = total + row_budget(r) + SETTLE + 2;
        #(total * PERIOD);
        $display("Run stopped by watchdog after %0d cycles", total);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int rd_base [arbiter_pkg::NUM_PORTS];
        int wr_base [arbiter_pkg::NUM_PORTS];
        logic [arbiter_pkg::NUM_PORTS-1:0] mask;
        logic [arbiter_pkg::WORD_BITS-1:0] exp_word;
        logic [arbiter_pkg::ADDR_BITS-1:0] addr;
        int cycles;
        int exp_n;
        int exp_s;
        int row_errors;
        int wv_base;
        bit done;

        clk         = 1'b0;
        reset       = 1'b1;
        load_valid  = 1'b0;
        load_mask   = '0;
        load_count  = '0;
        wait_cycles = '0;
        errors      = 0;
        passed      = 0;
        failed      = 0;
        for (int k = 0; k < arbiter_pkg::NUM_PORTS; k++) begin
            consumed[k] = 0;
            word_off[k] = 0;
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        // Nothing is loaded yet, so nothing may move
        repeat (IDLE) @(negedge clk);
        assert (i_models.activity == 0)
        else begin
            $display("ERROR at %0t: %0d active cycles while idle", $time, i_models.activity);
            errors++;
        end
        $display("idle check: %s", (i_models.activity == 0) ? "pass" : "fail");

        for (int r = 0; r < ROWS; r++) begin
            row_errors = errors;
            wv_base    = i_models.wait_violations;
            mask = (row_port[r] == ALL) ? 4'hf : 4'(1 << row_port[r]);
            for (int k = 0; k < arbiter_pkg::NUM_PORTS; k++) begin
                rd_base[k] = i_models.read_q[k].size();
                wr_base[k] = i_models.region_writes[k];
            end
            @(posedge clk);
            load_valid  <= 1'b1;
            load_mask   <= mask;
            load_count  <= 8'(row_load[r]);
            wait_cycles <= 8'(row_wait[r]);
            @(posedge clk);
            load_valid <= 1'b0;

            // Wait for every loaded port to get its bytes back
            cycles = 0;
            done   = 1'b0;
            while (!done && cycles < row_budget(r)) begin
                @(negedge clk);
                cycles++;
                done = 1'b1;
                for (int k = 0; k < arbiter_pkg::NUM_PORTS; k++)
                    if (mask[k] && i_models.read_q[k].size() < rd_base[k] + row_ret[r])
                        done = 1'b0;
            end
            if (!done) begin
                $display("Row %0d: read data did not come back within %0d cycles",
                         r, row_budget(r));
                errors++;
            end
            repeat (SETTLE) @(negedge clk);

            // No strobe may appear while the memory holds mem_wait high
            assert (i_models.wait_violations == wv_base)
            else begin
                $display("ERROR at %0t: %0d accesses while mem_wait was high",
                         $time, i_models.wait_violations - wv_base);
                errors++;
            end

            for (int k = 0; k < arbiter_pkg::NUM_PORTS; k++) begin
                exp_n = mask[k] ? row_ret[r] : 0;
                exp_s = mask[k] ? row_stored[r] : 0;
                assert (i_models.read_q[k].size() - rd_base[k] == exp_n)
                else begin
                    $display("ERROR at %0t: port %0d returned %0d bytes, expected %0d",
                             $time, k, i_models.read_q[k].size() - rd_base[k], exp_n);
                    errors++;
                end
                assert (2 * (i_models.region_writes[k] - wr_base[k]) == exp_s)
                else begin
                    $display("ERROR at %0t: region %0d got %0d words, expected %0d",
                             $time, k, i_models.region_writes[k] - wr_base[k], exp_s / 2);
                    errors++;
                end
                // Words in the region, lower byte in the low half
                for (int i = 0; i < exp_s / 2; i++) begin
                    addr = arbiter_pkg::ADDR_BITS'((k << arbiter_pkg::REGION_WORD_BITS)
                                                   + word_off[k] + i);
                    exp_word = {i_models.load_log[k][consumed[k] + 2 * i + 1],
                                i_models.load_log[k][consumed[k] + 2 * i]};
                    assert (i_models.mem[addr] == exp_word)
                    else begin
                        $display("ERROR at %0t: mem[%0h] = %04h, expected %04h",
                                 $time, addr, i_models.mem[addr], exp_word);
                        errors++;
                    end
                end
                // Returned bytes in load order
                for (int j = 0; j < exp_n && rd_base[k] + j < i_models.read_q[k].size(); j++) begin
                    assert (i_models.read_q[k][rd_base[k] + j]
                            == i_models.load_log[k][consumed[k] + j])
                    else begin
                        $display("ERROR at %0t: port %0d byte %0d = %02h, expected %02h",
                                 $time, k, j, i_models.read_q[k][rd_base[k] + j],
                                 i_models.load_log[k][consumed[k] + j]);
                        errors++;
                    end
                end
                consumed[k] = consumed[k] + exp_s;
                word_off[k] = word_off[k] + exp_s / 2;
            end

            if (errors == row_errors) begin
                passed++;
                $display("test %0d port %0d load %0d: pass", r, row_port[r], row_load[r]);
            end else begin
                failed++;
                $display("test %0d port %0d load %0d: fail", r, row_port[r], row_load[r]);
            end
        end

        $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
verilog/arbiter_pkg.sv
verilog/port_scanner.sv
verilog/word_assembler.sv
verilog/word_splitter.sv
verilog/memory_arbitrator.sv
tb/tb_port_models.sv
tb/tb_memory_arbitrator.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory arbitrator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_memory_arbitrator \
    -f tb.f \
    -o sim_tb
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Test FAILED" sim.log; then
    exit 1
fi

if ! grep -q "Test OK" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0
